/* sources.f */
logic/icache_pkg.sv
logic/sdp_ram.sv
logic/icache.sv
logic/wb_arbiter.sv
logic/inst_mem.sv
logic/fetch_subsys_top.sv
tb/tb_clk_gen.sv
tb/tb_fetch_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch subsystem testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_fetch_subsys
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_fetch_subsys \
  --Mdir "${BUILD_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
  echo "run_sim: Verilator build failed"
  exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG}" 2>&1
sim_status=$?
cat "${LOG}"
if [ ${sim_status} -ne 0 ]; then
  echo "run_sim: simulation exited with status ${sim_status}"
  exit 1
fi

if grep -F -q "*** PASSED ***" "${LOG}"; then
  echo "run_sim: pass"
  exit 0
else
  echo "run_sim: pass message not found in ${LOG}"
  exit 1
fi

/* tb/tb_fetch_subsys.sv */
// directed tests of the fetch subsystem against a reference model of memory and cache
// only the memory lines written through the loader port are ever fetched
// stops at the first error, run length bounded by a cycle counter
`timescale 1ns/1ps

module tb_fetch_subsys;
  import icache_pkg::*;

  localparam int SEED = 38;
  localparam int TIMEOUT_CYCLES = 3000;

  logic   clk;
  logic   rst_n;
  logic   req_valid_i;
  addr_t  req_addr_i;
  logic   req_ready_o;
  logic   rsp_valid_o;
  addr_t  rsp_addr_o;
  instr_t rsp_instr_o;
  logic   rsp_adef_o;
  logic   rsp_ready_i;
  logic   inv_valid_i;
  addr_t  inv_addr_i;
  logic   inv_ready_o;
  logic   ld_cyc_i;
  logic   ld_stb_i;
  logic   ld_we_i;
  addr_t  ld_adr_i;
  instr_t ld_wdat_i;
  logic   ld_ack_o;
  instr_t ld_rdat_o;

  // reference model of memory and cache contents
  instr_t mem_model [MEM_WORDS];
  tag_t   m_tag [WAY_NUM][SET_NUM];
  logic   m_valid [WAY_NUM][SET_NUM];
  instr_t m_data [WAY_NUM][SET_NUM][LINE_WORDS];
  logic   m_plru [SET_NUM];

  addr_t  fetch_q [$];
  int     stream_cycles;
  int     cycle_cnt = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_subsys_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_addr_o  (rsp_addr_o),
    .rsp_instr_o (rsp_instr_o),
    .rsp_adef_o  (rsp_adef_o),
    .rsp_ready_i (rsp_ready_i),
    .inv_valid_i (inv_valid_i),
    .inv_addr_i  (inv_addr_i),
    .inv_ready_o (inv_ready_o),
    .ld_cyc_i    (ld_cyc_i),
    .ld_stb_i    (ld_stb_i),
    .ld_we_i     (ld_we_i),
    .ld_adr_i    (ld_adr_i),
    .ld_wdat_i   (ld_wdat_i),
    .ld_ack_o    (ld_ack_o),
    .ld_rdat_o   (ld_rdat_o)
  );

  // ====================
  // helpers
  // ====================
  // word index appears twice so every address bit shows
  function automatic instr_t word_pattern(mem_addr_t idx);
    return {6'h2b, idx, 6'h11, idx};
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      report_failure($sformatf("MISMATCH %s %s expected %h actual %h", test, what, exp, act));
    end
  endtask

  // one classic write cycle on the loader port
  task automatic load_word(addr_t addr, instr_t data);
    @(posedge clk);
    ld_cyc_i <= 1'b1;
    ld_stb_i <= 1'b1;
    ld_we_i <= 1'b1;
    ld_adr_i <= addr;
    ld_wdat_i <= data;
    do @(negedge clk); while (!ld_ack_o);
    @(posedge clk);
    ld_cyc_i <= 1'b0;
    ld_stb_i <= 1'b0;
    ld_we_i <= 1'b0;
    mem_model[addr[11:2]] = data;
  endtask

  task automatic load_line(addr_t base);
    addr_t a;
    for (int i = 0; i < LINE_WORDS; i++) begin
      a = base + addr_t'(4 * i);
      load_word(a, word_pattern(a[11:2]));
    end
  endtask

  // one classic read cycle on the loader port, data compared with the model memory
  task automatic read_word(string test, addr_t addr);
    @(posedge clk);
    ld_cyc_i <= 1'b1;
    ld_stb_i <= 1'b1;
    ld_we_i <= 1'b0;
    ld_adr_i <= addr;
    do @(negedge clk); while (!ld_ack_o);
    check_value(test, "loader read", mem_model[addr[11:2]], ld_rdat_o);
    @(posedge clk);
    ld_cyc_i <= 1'b0;
    ld_stb_i <= 1'b0;
  endtask

  // expected response of one fetch, advancing the model cache
  function automatic void model_fetch(input addr_t addr, output instr_t instr,
                                      output logic adef);
    idx_t s;
    tag_t t;
    int   way;
    s = addr[7:4];
    t = addr[31:8];
    adef = (addr[1:0] != 2'b00);
    instr = '0;
    if (!adef && addr[UNCACHED_BIT]) begin
      instr = mem_model[addr[11:2]];
    end else if (!adef) begin
      way = -1;
      for (int w = 0; w < WAY_NUM; w++) begin
        if (m_valid[w][s] && (m_tag[w][s] == t)) begin
          way = w;
        end
      end
      // miss fills the way named by the plru bit
      if (way < 0) begin
        way = int'(m_plru[s]);
        for (int i = 0; i < LINE_WORDS; i++) begin
          m_data[way][s][i] = mem_model[{addr[11:4], 2'(i)}];
        end
        m_tag[way][s] = t;
        m_valid[way][s] = 1'b1;
      end
      instr = m_data[way][s][addr[3:2]];
      m_plru[s] = (way == 0);
    end
  endfunction

  task automatic invalidate_addr(addr_t addr);
    @(posedge clk);
    inv_valid_i <= 1'b1;
    inv_addr_i <= addr;
    do @(negedge clk); while (!inv_ready_o);
    @(posedge clk);
    inv_valid_i <= 1'b0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (m_valid[w][addr[7:4]] && (m_tag[w][addr[7:4]] == addr[31:8])) begin
        m_valid[w][addr[7:4]] = 1'b0;
      end
    end
  endtask

  // issues every address in fetch_q and checks responses in order
  task automatic run_stream(string test, bit stalls);
    instr_t exp_instr [$];
    logic   exp_adef [$];
    addr_t  exp_addr [$];
    instr_t e_instr;
    logic   e_adef;
    int     total;
    int     n_req;
    int     n_rsp;
    logic   held;
    addr_t  h_addr;
    instr_t h_instr;
    logic   h_adef;
    total = fetch_q.size();
    foreach (fetch_q[i]) begin
      model_fetch(fetch_q[i], e_instr, e_adef);
      exp_addr.push_back(fetch_q[i]);
      exp_instr.push_back(e_instr);
      exp_adef.push_back(e_adef);
    end
    n_req = 0;
    n_rsp = 0;
    held = 1'b0;
    stream_cycles = 0;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_addr_i <= fetch_q[0];
    rsp_ready_i <= stalls ? ($urandom_range(0, 3) != 0) : 1'b1;
    while (n_rsp < total) begin
      @(negedge clk);
      stream_cycles++;
      assert (!ld_ack_o) else begin
        report_failure($sformatf("%s: loader port saw an acknowledge it never asked for", test));
      end
      if (held) begin
        assert (rsp_valid_o && (rsp_addr_o === h_addr) && (rsp_instr_o === h_instr) &&
                (rsp_adef_o === h_adef)) else begin
          report_failure($sformatf("%s: response for %h changed while stalled", test, h_addr));
        end
      end
      held = rsp_valid_o && !rsp_ready_i;
      h_addr = rsp_addr_o;
      h_instr = rsp_instr_o;
      h_adef = rsp_adef_o;
      if (rsp_valid_o && rsp_ready_i) begin
        check_value(test, "address", exp_addr[n_rsp], rsp_addr_o);
        check_value(test, "instruction", exp_instr[n_rsp], rsp_instr_o);
        check_value(test, "adef", {31'b0, exp_adef[n_rsp]}, {31'b0, rsp_adef_o});
        n_rsp++;
      end
      if (req_valid_i && req_ready_o) begin
        n_req++;
      end
      @(posedge clk);
      req_valid_i <= (n_req < total);
      if (n_req < total) begin
        req_addr_i <= fetch_q[n_req];
      end
      rsp_ready_i <= stalls ? ($urandom_range(0, 3) != 0) : 1'b1;
    end
    rsp_ready_i <= 1'b1;
    fetch_q.delete();
  endtask

  // ====================
  // tests
  // ====================
  task automatic cold_miss_then_hits();
    load_line(32'h0000_0100);
    for (int i = 0; i < LINE_WORDS; i++) begin
      fetch_q.push_back(32'h0000_0100 + addr_t'(4 * i));
    end
    run_stream("cold_miss_then_hits", 1'b0);
    for (int i = 0; i < LINE_WORDS; i++) begin
      fetch_q.push_back(32'h0000_0100 + addr_t'(4 * i));
    end
    run_stream("cold_miss_then_hits", 1'b0);
    // all hits, one response per cycle after a one-cycle start
    check_value("cold_miss_then_hits", "hit stream cycles", 32'(LINE_WORDS + 1),
                32'(stream_cycles));
  endtask

  task automatic stale_vs_uncached();
    load_word(32'h0000_0104, ~word_pattern(10'h041));
    read_word("stale_vs_uncached", 32'h0000_0104);
    fetch_q.push_back(32'h0000_0104);
    fetch_q.push_back(32'h8000_0104);
    run_stream("stale_vs_uncached", 1'b0);
  endtask

  task automatic invalidate_line();
    invalidate_addr(32'h0000_0104);
    fetch_q.push_back(32'h0000_0104);
    run_stream("invalidate_line", 1'b0);
    // same set, tag not present
    load_word(32'h0000_0108, ~word_pattern(10'h042));
    invalidate_addr(32'h0000_0500);
    fetch_q.push_back(32'h0000_0108);
    run_stream("invalidate_line", 1'b0);
  endtask

  task automatic plru_replacement();
    load_line(32'h0000_0130);
    load_line(32'h0000_0230);
    load_line(32'h0000_0330);
    fetch_q.push_back(32'h0000_0130);
    fetch_q.push_back(32'h0000_0230);
    fetch_q.push_back(32'h0000_0130);
    fetch_q.push_back(32'h0000_0330);
    run_stream("plru_replacement", 1'b0);
    load_word(32'h0000_0130, ~word_pattern(10'h04c));
    load_word(32'h0000_0230, ~word_pattern(10'h08c));
    fetch_q.push_back(32'h0000_0130);
    fetch_q.push_back(32'h0000_0230);
    run_stream("plru_replacement", 1'b0);
  endtask

  task automatic misaligned_fetch();
    fetch_q.push_back(32'h0000_0102);
    fetch_q.push_back(32'h0000_0100);
    fetch_q.push_back(32'h8000_0001);
    fetch_q.push_back(32'h0000_010c);
    run_stream("misaligned_fetch", 1'b0);
  endtask

  task automatic random_backpressure();
    addr_t lines [5];
    addr_t a;
    int    kind;
    lines[0] = 32'h0000_0100;
    lines[1] = 32'h0000_0130;
    lines[2] = 32'h0000_0230;
    lines[3] = 32'h0000_0330;
    lines[4] = 32'h0000_0150;
    load_line(32'h0000_0150);
    for (int i = 0; i < 24; i++) begin
      a = lines[$urandom_range(0, 4)] + addr_t'(4 * $urandom_range(0, 3));
      kind = int'($urandom_range(0, 7));
      if (kind == 0) begin
        a[UNCACHED_BIT] = 1'b1;
      end else if (kind == 1) begin
        a[1:0] = 2'($urandom_range(1, 3));
      end
      fetch_q.push_back(a);
    end
    run_stream("random_backpressure", 1'b1);
  endtask

  // ====================
  // run control
  // ====================
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout: tests did not finish within %0d cycles", cycle_cnt));
    end
  end

  initial begin
    void'($urandom(SEED));
    req_valid_i = 1'b0;
    req_addr_i = '0;
    rsp_ready_i = 1'b1;
    inv_valid_i = 1'b0;
    inv_addr_i = '0;
    ld_cyc_i = 1'b0;
    ld_stb_i = 1'b0;
    ld_we_i = 1'b0;
    ld_adr_i = '0;
    ld_wdat_i = '0;
    for (int s = 0; s < SET_NUM; s++) begin
      m_plru[s] = 1'b0;
      for (int w = 0; w < WAY_NUM; w++) begin
        m_valid[w][s] = 1'b0;
        m_tag[w][s] = '0;
      end
    end
    wait (rst_n === 1'b1);
    repeat (2) @(posedge clk);
    cold_miss_then_hits();
    stale_vs_uncached();
    invalidate_line();
    plru_replacement();
    misaligned_fetch();
    random_backpressure();
    repeat (2) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
// clock and active-low reset for the fetch subsystem testbench
// 40 ns period, reset held low for the first 4 rising edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD_NS = 20;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* logic/fetch_subsys_top.sv */
// fetch subsystem: instruction cache and loader sharing one word memory
// refills wait while the loader owns the bus
`timescale 1ns/1ps

module fetch_subsys_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  icache_pkg::addr_t  req_addr_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output icache_pkg::addr_t  rsp_addr_o,
  output icache_pkg::instr_t rsp_instr_o,
  output logic               rsp_adef_o,
  input  logic               rsp_ready_i,
  input  logic               inv_valid_i,
  input  icache_pkg::addr_t  inv_addr_i,
  output logic               inv_ready_o,
  input  logic               ld_cyc_i,
  input  logic               ld_stb_i,
  input  logic               ld_we_i,
  input  icache_pkg::addr_t  ld_adr_i,
  input  icache_pkg::instr_t ld_wdat_i,
  output logic               ld_ack_o,
  output icache_pkg::instr_t ld_rdat_o
);
  import icache_pkg::*;

  // cache master side
  logic   c_cyc;
  logic   c_stb;
  addr_t  c_adr;
  logic   c_ack;
  instr_t c_rdat;
  // memory side
  logic   s_cyc;
  logic   s_stb;
  logic   s_we;
  addr_t  s_adr;
  instr_t s_wdat;
  logic   s_ack;
  instr_t s_rdat;

  icache u_icache (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_addr_o  (rsp_addr_o),
    .rsp_instr_o (rsp_instr_o),
    .rsp_adef_o  (rsp_adef_o),
    .rsp_ready_i (rsp_ready_i),
    .inv_valid_i (inv_valid_i),
    .inv_addr_i  (inv_addr_i),
    .inv_ready_o (inv_ready_o),
    .wb_cyc_o    (c_cyc),
    .wb_stb_o    (c_stb),
    .wb_adr_o    (c_adr),
    .wb_ack_i    (c_ack),
    .wb_rdat_i   (c_rdat)
  );

  wb_arbiter u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .m0_cyc_i  (ld_cyc_i),
    .m0_stb_i  (ld_stb_i),
    .m0_we_i   (ld_we_i),
    .m0_adr_i  (ld_adr_i),
    .m0_wdat_i (ld_wdat_i),
    .m0_ack_o  (ld_ack_o),
    .m0_rdat_o (ld_rdat_o),
    .m1_cyc_i  (c_cyc),
    .m1_stb_i  (c_stb),
    .m1_adr_i  (c_adr),
    .m1_ack_o  (c_ack),
    .m1_rdat_o (c_rdat),
    .s_cyc_o   (s_cyc),
    .s_stb_o   (s_stb),
    .s_we_o    (s_we),
    .s_adr_o   (s_adr),
    .s_wdat_o  (s_wdat),
    .s_ack_i   (s_ack),
    .s_rdat_i  (s_rdat)
  );

  inst_mem u_inst_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc_i  (s_cyc),
    .wb_stb_i  (s_stb),
    .wb_we_i   (s_we),
    .wb_adr_i  (s_adr),
    .wb_wdat_i (s_wdat),
    .wb_ack_o  (s_ack),
    .wb_rdat_o (s_rdat)
  );

endmodule

/* logic/inst_mem.sv */
// wishbone classic word memory, 1024 words, byte selects not supported
// address bits 11 to 2 pick the word, so uncached addresses alias cached ones
`timescale 1ns/1ps

module inst_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  icache_pkg::addr_t  wb_adr_i,
  input  icache_pkg::instr_t wb_wdat_i,
  output logic               wb_ack_o,
  output icache_pkg::instr_t wb_rdat_o
);
  import icache_pkg::*;

  mem_addr_t word_idx;
  logic      strobe;
  logic      ack_q;

  assign word_idx = wb_adr_i[11:2];
  // new strobe only, the ack cycle is not a second access
  assign strobe = wb_cyc_i && wb_stb_i && !ack_q;

  // ack one cycle after the strobe, low again the cycle after
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= strobe;
    end
  end

  assign wb_ack_o = ack_q;

  // registered read lines up with the ack
  sdp_ram #(.DEPTH(MEM_WORDS), .WIDTH($bits(instr_t))) u_ram (
    .clk     (clk),
    .we_i    (strobe && wb_we_i),
    .waddr_i (word_idx),
    .wdata_i (wb_wdat_i),
    .raddr_i (word_idx),
    .rdata_o (wb_rdat_o)
  );

endmodule

/* logic/wb_arbiter.sv */
// two-master wishbone classic arbiter, loader (m0) before cache (m1)
// grant takes one cycle from an idle bus and is kept while the owner holds cyc
`timescale 1ns/1ps

module wb_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               m0_cyc_i,
  input  logic               m0_stb_i,
  input  logic               m0_we_i,
  input  icache_pkg::addr_t  m0_adr_i,
  input  icache_pkg::instr_t m0_wdat_i,
  output logic               m0_ack_o,
  output icache_pkg::instr_t m0_rdat_o,
  input  logic               m1_cyc_i,
  input  logic               m1_stb_i,
  input  icache_pkg::addr_t  m1_adr_i,
  output logic               m1_ack_o,
  output icache_pkg::instr_t m1_rdat_o,
  output logic               s_cyc_o,
  output logic               s_stb_o,
  output logic               s_we_o,
  output icache_pkg::addr_t  s_adr_o,
  output icache_pkg::instr_t s_wdat_o,
  input  logic               s_ack_i,
  input  icache_pkg::instr_t s_rdat_i
);

  typedef enum logic [1:0] {GNT_NONE, GNT_LOADER, GNT_CACHE} gnt_e;

  gnt_e gnt_q;
  gnt_e gnt_d;
  logic gnt_ld;
  logic gnt_c;

  // hand over directly when the owner drops cyc and the other is waiting
  always_comb begin
    gnt_d = gnt_q;
    case (gnt_q)
      GNT_LOADER: begin
        if (!m0_cyc_i) begin
          gnt_d = m1_cyc_i ? GNT_CACHE : GNT_NONE;
        end
      end
      GNT_CACHE: begin
        if (!m1_cyc_i) begin
          gnt_d = m0_cyc_i ? GNT_LOADER : GNT_NONE;
        end
      end
      default: begin
        if (m0_cyc_i) begin
          gnt_d = GNT_LOADER;
        end else if (m1_cyc_i) begin
          gnt_d = GNT_CACHE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q <= GNT_NONE;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  assign gnt_ld = (gnt_q == GNT_LOADER);
  assign gnt_c = (gnt_q == GNT_CACHE);

  // slave side follows the owner only
  assign s_cyc_o = (gnt_ld && m0_cyc_i) || (gnt_c && m1_cyc_i);
  assign s_stb_o = (gnt_ld && m0_cyc_i && m0_stb_i) || (gnt_c && m1_cyc_i && m1_stb_i);
  // cache only reads
  assign s_we_o = gnt_ld && m0_we_i;
  assign s_adr_o = gnt_c ? m1_adr_i : m0_adr_i;
  assign s_wdat_o = gnt_ld ? m0_wdat_i : '0;

  assign m0_ack_o = gnt_ld && s_ack_i;
  assign m1_ack_o = gnt_c && s_ack_i;
  assign m0_rdat_o = s_rdat_i;
  assign m1_rdat_o = s_rdat_i;

endmodule

/* logic/icache.sv */
// two-way set-associative instruction cache, one word per fetch, no MMU
// hit way select and PLRU assume exactly two ways
// refill is four single wishbone classic reads under one held cyc
`timescale 1ns/1ps

module icache (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  icache_pkg::addr_t  req_addr_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output icache_pkg::addr_t  rsp_addr_o,
  output icache_pkg::instr_t rsp_instr_o,
  output logic               rsp_adef_o,
  input  logic               rsp_ready_i,
  input  logic               inv_valid_i,
  input  icache_pkg::addr_t  inv_addr_i,
  output logic               inv_ready_o,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output icache_pkg::addr_t  wb_adr_o,
  input  logic               wb_ack_i,
  input  icache_pkg::instr_t wb_rdat_i
);
  import icache_pkg::*;

  typedef enum logic [1:0] {IDLE, REFILL, REPLAY, UNCACHED} state_e;

  state_e                            state_q;
  logic                              run_q;
  logic                              s1_fetch_q;
  logic                              s1_inv_q;
  logic                              s1_adef_q;
  addr_t                             s1_addr_q;
  logic                              s1_adv;
  logic                              s1_uncached;
  idx_t                              s1_idx;
  tag_t                              s1_tag;
  addr_t                             s0_addr;
  idx_t                              rd_idx;
  tag_t                              tag_rd [WAY_NUM];
  line_t                             data_rd [WAY_NUM];
  logic [WAY_NUM-1:0]                tag_match;
  logic [WAY_NUM-1:0]                way_we;
  logic                              hit;
  logic                              hit_way;
  logic                              repl_way;
  line_t                             hit_line;
  line_t                             fill_line;
  line_t                             line_q;
  logic [WORD_SEL_W-1:0]             beat_q;
  logic                              last_beat;
  logic                              fill_done;
  logic                              miss_start;
  logic                              rsp_fire;
  logic [WAY_NUM-1:0][SET_NUM-1:0]   valid_q;
  logic [SET_NUM-1:0]                plru_q;

  // ====================
  // stage 0
  // ====================
  // invalidate wins over a fetch in the same cycle
  assign s0_addr = inv_valid_i ? inv_addr_i : req_addr_i;
  // hold the stage-1 index when stalled, which also serves the replay
  assign rd_idx = s1_adv ? s0_addr[7:4] : s1_idx;

  assign s1_adv = !s1_fetch_q || rsp_fire;
  assign inv_ready_o = run_q && s1_adv;
  assign req_ready_o = run_q && s1_adv && !inv_valid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
      s1_fetch_q <= 1'b0;
      s1_inv_q <= 1'b0;
      s1_adef_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (s1_adv) begin
        s1_fetch_q <= req_valid_i && req_ready_o;
        s1_inv_q <= inv_valid_i && inv_ready_o;
        s1_adef_q <= req_valid_i && req_ready_o && (req_addr_i[1:0] != 2'b00);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_adv) begin
      s1_addr_q <= s0_addr;
    end
  end

  // ====================
  // stage 1
  // ====================
  assign s1_idx = s1_addr_q[7:4];
  assign s1_tag = s1_addr_q[31:8];
  assign s1_uncached = s1_addr_q[UNCACHED_BIT];

  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      tag_match[w] = valid_q[w][s1_idx] && (tag_rd[w] == s1_tag);
    end
  end

  assign hit = |tag_match;
  assign hit_way = tag_match[1];
  assign repl_way = plru_q[s1_idx];
  assign hit_line = data_rd[hit_way];

  assign rsp_valid_o = s1_fetch_q && (s1_adef_q || (state_q == UNCACHED) ||
                                      ((state_q == IDLE) && !s1_uncached && hit));
  assign rsp_fire = rsp_valid_o && rsp_ready_i;
  assign rsp_addr_o = s1_addr_q;
  assign rsp_adef_o = s1_adef_q;

  always_comb begin
    if (s1_adef_q) begin
      rsp_instr_o = '0;
    end else if (state_q == UNCACHED) begin
      // uncached word sits in the low word of the buffer
      rsp_instr_o = line_q[31:0];
    end else begin
      rsp_instr_o = hit_line[{s1_addr_q[3:2], 5'b0} +: 32];
    end
  end

  // ====================
  // refill / uncached
  // ====================
  assign miss_start = (state_q == IDLE) && s1_fetch_q && !s1_adef_q && (s1_uncached || !hit);
  assign last_beat = s1_uncached || (beat_q == WORD_SEL_W'(LINE_WORDS - 1));
  assign fill_done = (state_q == REFILL) && wb_ack_i && last_beat && !s1_uncached;
  // last beat goes straight into the RAM write
  assign fill_line = {wb_rdat_i, line_q[(LINE_WORDS-1)*32-1:0]};

  assign wb_cyc_o = (state_q == REFILL);
  assign wb_stb_o = (state_q == REFILL);
  assign wb_adr_o = s1_uncached ? s1_addr_q : {s1_addr_q[31:WORD_SEL_W+2], beat_q, 2'b00};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          beat_q <= '0;
          if (miss_start) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (wb_ack_i) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              state_q <= s1_uncached ? UNCACHED : REPLAY;
            end
          end
        end
        REPLAY: state_q <= IDLE;
        default: begin
          if (rsp_ready_i) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == REFILL) && wb_ack_i) begin
      line_q[{beat_q, 5'b0} +: 32] <= wb_rdat_i;
    end
  end

  // valid bits and PLRU, bit set means way 1 is next to replace
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      plru_q <= '0;
    end else begin
      if (fill_done) begin
        valid_q[repl_way][s1_idx] <= 1'b1;
      end
      if (s1_inv_q) begin
        for (int w = 0; w < WAY_NUM; w++) begin
          if (tag_match[w]) begin
            valid_q[w][s1_idx] <= 1'b0;
          end
        end
      end
      if (rsp_fire && (state_q == IDLE) && !s1_adef_q && !s1_uncached) begin
        plru_q[s1_idx] <= !hit_way;
      end
    end
  end

  // ====================
  // tag and data RAMs
  // ====================
  for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
    assign way_we[w] = fill_done && (repl_way == w);

    sdp_ram #(.DEPTH(SET_NUM), .WIDTH($bits(line_t))) u_data_ram (
      .clk     (clk),
      .we_i    (way_we[w]),
      .waddr_i (s1_idx),
      .wdata_i (fill_line),
      .raddr_i (rd_idx),
      .rdata_o (data_rd[w])
    );

    sdp_ram #(.DEPTH(SET_NUM), .WIDTH($bits(tag_t))) u_tag_ram (
      .clk     (clk),
      .we_i    (way_we[w]),
      .waddr_i (s1_idx),
      .wdata_i (s1_tag),
      .raddr_i (rd_idx),
      .rdata_o (tag_rd[w])
    );
  end

endmodule

/* logic/sdp_ram.sv */
// simple dual-port RAM, one write port and one registered read port
// same-cycle read of the written address returns the new data
// no reset, contents are undefined until written
`timescale 1ns/1ps

module sdp_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    // write first on an address collision
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

/* logic/icache_pkg.sv */
// widths and geometry for the fetch path
// geometry is fixed at 2 ways, 16 sets and 16-byte lines over a 4 KiB memory
package icache_pkg;

  // ====================
  // geometry
  // ====================
  localparam int WAY_NUM = 2;
  localparam int SET_NUM = 16;
  localparam int LINE_WORDS = 4;
  localparam int MEM_WORDS = 1024;

  // address bit that selects an uncached fetch
  localparam int UNCACHED_BIT = 31;

  // derived field widths
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(SET_NUM);
  localparam int TAG_W = 32 - IDX_W - WORD_SEL_W - 2;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

  // ====================
  // vector types
  // ====================
  // byte address
  typedef logic [31:0] addr_t;
  // one instruction or memory word
  typedef logic [31:0] instr_t;
  // four words, word 0 in the low bits
  typedef logic [LINE_WORDS*32-1:0] line_t;
  // address bits 31 to 8
  typedef logic [TAG_W-1:0] tag_t;
  // address bits 7 to 4
  typedef logic [IDX_W-1:0] idx_t;
  // address bits 11 to 2
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage
